// ==== src/axi_bridge_defines.svh ====
// widths, register map size and acknowledge timeout for the axi to system bus bridge
`ifndef AXI_BRIDGE_DEFINES_SVH
`define AXI_BRIDGE_DEFINES_SVH

//////////////////////////////////////////////////
// axi side
//////////////////////////////////////////////////

`define AXI_DATA_W 32   // data bus in bits
`define AXI_ADDR_W 32   // byte address
`define AXI_ID_W   4    // transaction id

//////////////////////////////////////////////////
// register bank and bus watchdog
//////////////////////////////////////////////////

// registers start at address 0, one per 4-byte word
`define REG_COUNT 8

// cycles after a bus strobe before the bridge gives up on ack
`define ACK_TIMEOUT 32

`endif

// ==== src/axi_pkg.sv ====
// axi width typedefs, response and size codes, and channel payload structs
`include "axi_bridge_defines.svh"

package axi_pkg;

   // widths with a meaning on the axi side
   typedef logic [`AXI_DATA_W-1:0]   axi_data_t;
   typedef logic [`AXI_ADDR_W-1:0]   axi_addr_t;
   typedef logic [`AXI_ID_W-1:0]     axi_id_t;
   typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;   // one bit per data byte
   typedef logic [1:0]               axi_resp_t;
   typedef logic [3:0]               axi_len_t;    // axi3 burst length minus one
   typedef logic [2:0]               axi_size_t;   // log2 of bytes per beat

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // the only transfer size served
   localparam axi_size_t SIZE_4B = 3'd2;

   // address beat, shared by aw and ar
   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
      axi_size_t size;
   } axi_ax_t;

   // write data beat, id kept for the axi3 wire set
   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_strb_t strb;
   } axi_w_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } axi_b_t;

   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_resp_t resp;
      logic      last;
   } axi_r_t;

endpackage

// ==== src/sys_bus_pkg.sv ====
// system bus width typedefs, request and response structs, controller state enum
`include "axi_bridge_defines.svh"

package sys_bus_pkg;

   // bus widths follow the axi side one to one
   typedef logic [`AXI_ADDR_W-1:0]   sys_addr_t;
   typedef logic [`AXI_DATA_W-1:0]   sys_data_t;
   typedef logic [`AXI_DATA_W/8-1:0] sys_sel_t;   // byte selects

   // request fields, qualified by wen or ren
   typedef struct packed {
      sys_addr_t addr;
      sys_data_t wdata;
      sys_sel_t  sel;
   } sys_req_t;

   // ack is a one cycle pulse, rdata valid with it
   typedef struct packed {
      sys_data_t rdata;
      logic      ack;
   } sys_rsp_t;

   // bridge transaction sequencer
   typedef enum logic [2:0] {
      IDLE,      // aw/ar open
      WR_DATA,   // waiting for the w beat
      WR_BUS,    // wen issued, waiting for ack
      RD_BUS,    // ren issued, waiting for ack
      WR_RESP,   // b beat pending
      RD_RESP    // r beat pending
   } bridge_state_t;

endpackage

// ==== src/axi_wr_capture.sv ====
// write address and write data beat registers with unsupported write flag
module axi_wr_capture (
   input  logic               axi,
   input  logic               rst,
   input  axi_pkg::axi_ax_t   aw,
   input  axi_pkg::axi_w_t    w,
   input  logic               aw_load,
   input  logic               w_load,
   output axi_pkg::axi_id_t   wr_id,
   output axi_pkg::axi_addr_t wr_addr,
   output axi_pkg::axi_data_t wr_data,
   output axi_pkg::axi_strb_t wr_strb,
   output logic               wr_unsup
);
   import axi_pkg::*;

   axi_len_t  wr_len;
   axi_size_t wr_size;
   logic      aw_seen;   // aw taken, w still owed

   // aw payload
   always_ff @(posedge axi) begin
      if (aw_load) begin
         wr_id   <= aw.id;
         wr_addr <= aw.addr;
      end
   end

   // w payload, strobes become byte selects later
   always_ff @(posedge axi) begin
      if (w_load) begin
         wr_data <= w.data;
         wr_strb <= w.strb;
      end
   end

   // beat shape and aw/w pairing
   always_ff @(posedge axi) begin
      if (rst) begin
         wr_len  <= '0;
         wr_size <= SIZE_4B;
         aw_seen <= 1'b0;
      end else begin
         if (aw_load) begin
            wr_len  <= aw.len;
            wr_size <= aw.size;
         end
         if (aw_load)
            aw_seen <= 1'b1;
         else if (w_load)
            aw_seen <= 1'b0;   // pair closed
      end
   end

   // burst or anything but a full word
   assign wr_unsup = (wr_len != '0) || (wr_size != SIZE_4B);

   // controller must never open w before an address is held
   a_w_after_aw: assert property (@(posedge axi) disable iff (rst) w_load |-> aw_seen)
      else $error("w_load without a preceding aw_load");

endmodule

// ==== src/axi_rd_capture.sv ====
// read address beat register with unsupported read flag
module axi_rd_capture (
   input  logic               axi,
   input  logic               rst,
   input  axi_pkg::axi_ax_t   ar,
   input  logic               ar_load,
   output axi_pkg::axi_id_t   rd_id,
   output axi_pkg::axi_addr_t rd_addr,
   output logic               rd_unsup
);
   import axi_pkg::*;

   axi_len_t  rd_len;
   axi_size_t rd_size;

   // ar payload, held until the next ar transfer
   always_ff @(posedge axi) begin
      if (ar_load) begin
         rd_id   <= ar.id;
         rd_addr <= ar.addr;
      end
   end

   // beat shape
   always_ff @(posedge axi) begin
      if (rst) begin
         rd_len  <= '0;
         rd_size <= SIZE_4B;
      end else if (ar_load) begin
         rd_len  <= ar.len;
         rd_size <= ar.size;
      end
   end

   // bursts and narrow/wide reads get slverr, no bus access
   assign rd_unsup = (rd_len != '0) || (rd_size != SIZE_4B);

endmodule

// ==== src/bridge_ctrl.sv ====
// transaction fsm with write priority, bus strobes, address mux and ack timeout
`include "axi_bridge_defines.svh"

module bridge_ctrl (
   input  logic                  axi,
   input  logic                  rst,
   // axi handshakes
   input  logic                  awvalid,
   output logic                  awready,
   input  logic                  wvalid,
   output logic                  wready,
   input  logic                  arvalid,
   output logic                  arready,
   output logic                  aw_load,
   output logic                  w_load,
   output logic                  ar_load,
   // captured request fields
   input  axi_pkg::axi_addr_t    wr_addr,
   input  axi_pkg::axi_data_t    wr_data,
   input  axi_pkg::axi_strb_t    wr_strb,
   input  logic                  wr_unsup,
   input  axi_pkg::axi_addr_t    rd_addr,
   input  logic                  rd_unsup,
   // system bus
   output sys_bus_pkg::sys_req_t sys_req,
   output logic                  wen,
   output logic                  ren,
   input  sys_bus_pkg::sys_rsp_t sys_rsp,
   // response generator
   output logic                  b_set,
   output logic                  r_set,
   output logic                  resp_err,
   output axi_pkg::axi_data_t    rd_data,
   input  logic                  resp_done
);
   import sys_bus_pkg::*;

   localparam int CNT_W = $clog2(`ACK_TIMEOUT + 1);

   bridge_state_t    state;
   bridge_state_t    state_nxt;
   logic [CNT_W-1:0] ack_cnt;     // cycles since the bus strobe
   logic             bus_state;
   logic             rd_side;     // read owns the bus address
   logic             timeout;

   //////////////////////////////////////////////////
   // axi handshakes
   //////////////////////////////////////////////////

   assign awready = (state == IDLE);
   assign arready = (state == IDLE) && !awvalid;   // write wins a tie
   assign wready  = (state == WR_DATA);

   assign aw_load = awvalid && awready;
   assign w_load  = wvalid && wready;
   assign ar_load = arvalid && arready;

   //////////////////////////////////////////////////
   // sequencer
   //////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      b_set     = 1'b0;
      r_set     = 1'b0;
      resp_err  = 1'b0;
      case (state)
         IDLE: begin
            if (aw_load)
               state_nxt = WR_DATA;
            else if (ar_load)
               state_nxt = RD_BUS;
         end
         WR_DATA: begin
            if (w_load && wr_unsup) begin   // w beat swallowed without a wen
               state_nxt = WR_RESP;
               b_set     = 1'b1;
               resp_err  = 1'b1;
            end else if (w_load) begin
               state_nxt = WR_BUS;
            end
         end
         WR_BUS: begin
            if (sys_rsp.ack || timeout) begin
               state_nxt = WR_RESP;
               b_set     = 1'b1;
               resp_err  = !sys_rsp.ack;
            end
         end
         RD_BUS: begin
            // unsupported read leaves in its first cycle
            if (rd_unsup || sys_rsp.ack || timeout) begin
               state_nxt = RD_RESP;
               r_set     = 1'b1;
               resp_err  = rd_unsup || !sys_rsp.ack;
            end
         end
         WR_RESP, RD_RESP: begin
            if (resp_done)
               state_nxt = IDLE;
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge axi) begin
      if (rst) begin
         state   <= IDLE;
         ack_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (bus_state)
            ack_cnt <= ack_cnt + 1'b1;
         else
            ack_cnt <= '0;   // zero in the strobe cycle
      end
   end

   assign bus_state = (state == WR_BUS) || (state == RD_BUS);
   assign timeout   = (ack_cnt == CNT_W'(`ACK_TIMEOUT));

   //////////////////////////////////////////////////
   // system bus side
   //////////////////////////////////////////////////

   // strobes only in the first bus cycle
   assign wen = (state == WR_BUS) && (ack_cnt == '0);
   assign ren = (state == RD_BUS) && (ack_cnt == '0) && !rd_unsup;

   assign rd_side       = (state == RD_BUS) || (state == RD_RESP);
   assign sys_req.addr  = rd_side ? rd_addr : wr_addr;
   assign sys_req.wdata = wr_data;
   assign sys_req.sel   = rd_side ? '1 : wr_strb;   // reads fetch the whole word

   // r beat data zeroed on error
   always_ff @(posedge axi) begin
      if (r_set)
         rd_data <= sys_rsp.ack ? sys_rsp.rdata : '0;
   end

   a_ack_in_bus: assert property (@(posedge axi) disable iff (rst)
      sys_rsp.ack |-> bus_state && (ack_cnt != '0))
      else $error("bus ack without a pending strobe");

   a_strobe_after_beat: assert property (@(posedge axi) disable iff (rst)
      (wen || ren) |-> $past(w_load || ar_load))
      else $error("bus strobe not one cycle after its axi beat");

endmodule

// ==== src/axi_resp_gen.sv ====
// b and r channel response registers held until accepted by the master
module axi_resp_gen (
   input  logic               axi,
   input  logic               rst,
   input  logic               b_set,
   input  logic               r_set,
   input  logic               resp_err,
   input  axi_pkg::axi_id_t   wr_id,
   input  axi_pkg::axi_id_t   rd_id,
   input  axi_pkg::axi_data_t rd_data,
   output logic               bvalid,
   output axi_pkg::axi_b_t    b,
   input  logic               bready,
   output logic               rvalid,
   output axi_pkg::axi_r_t    r,
   input  logic               rready,
   output logic               resp_done
);
   import axi_pkg::*;

   axi_id_t   b_id_q;
   axi_id_t   r_id_q;
   axi_resp_t b_resp_q;
   axi_resp_t r_resp_q;
   axi_resp_t set_resp;

   assign set_resp = resp_err ? RESP_SLVERR : RESP_OKAY;

   // valids, dropped on the transfer
   always_ff @(posedge axi) begin
      if (rst) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         if (b_set)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         if (r_set)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge axi) begin
      if (b_set) begin
         b_id_q   <= wr_id;
         b_resp_q <= set_resp;
      end
      if (r_set) begin
         r_id_q   <= rd_id;
         r_resp_q <= set_resp;
      end
   end

   assign b = '{id: b_id_q, resp: b_resp_q};
   // data comes straight from the controller's held word
   assign r = '{id: r_id_q, data: rd_data, resp: r_resp_q, last: 1'b1};

   assign resp_done = (bvalid && bready) || (rvalid && rready);

   a_b_hold: assert property (@(posedge axi) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(b))
      else $error("b beat changed before bready");

   a_r_hold: assert property (@(posedge axi) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(r))
      else $error("r beat changed before rready");

endmodule

// ==== src/sys_reg_bank.sv ====
// system bus slave with byte-selectable registers, acks mapped addresses only
`include "axi_bridge_defines.svh"

module sys_reg_bank (
   input  logic                  axi,
   input  logic                  rst,
   input  sys_bus_pkg::sys_req_t sys_req,
   input  logic                  wen,
   input  logic                  ren,
   output sys_bus_pkg::sys_rsp_t sys_rsp
);
   import sys_bus_pkg::*;

   localparam int IDX_W = $clog2(`REG_COUNT);

   sys_data_t        regs [`REG_COUNT];
   logic [IDX_W-1:0] idx;      // word index
   logic             mapped;
   logic             ack_q;
   sys_data_t        rdata_q;

   //////////////////////////////////////////////////
   // decode
   //////////////////////////////////////////////////

   assign idx    = sys_req.addr[2 +: IDX_W];   // byte offset ignored
   assign mapped = (sys_req.addr < `REG_COUNT * 4);

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   always_ff @(posedge axi) begin
      if (rst) begin
         for (int i = 0; i < `REG_COUNT; i++)
            regs[i] <= '0;
      end else if (wen && mapped) begin
         for (int k = 0; k < $bits(sys_sel_t); k++) begin
            if (sys_req.sel[k])
               regs[idx][8*k +: 8] <= sys_req.wdata[8*k +: 8];   // selected byte lanes only
         end
      end
   end

   // ack one cycle after the strobe, silence off the map
   always_ff @(posedge axi) begin
      if (rst)
         ack_q <= 1'b0;
      else
         ack_q <= (wen || ren) && mapped;
   end

   always_ff @(posedge axi) begin
      if (ren && mapped)
         rdata_q <= regs[idx];
   end

   assign sys_rsp = '{rdata: rdata_q, ack: ack_q};

endmodule

// ==== src/axi_sys_bridge_top.sv ====
// bridge top with write/read capture, controller, response generator and register bank
module axi_sys_bridge_top (
   input  logic             axi,
   input  logic             rst,
   input  axi_pkg::axi_ax_t aw,
   input  logic             awvalid,
   output logic             awready,
   input  axi_pkg::axi_w_t  w,
   input  logic             wvalid,
   output logic             wready,
   output axi_pkg::axi_b_t  b,
   output logic             bvalid,
   input  logic             bready,
   input  axi_pkg::axi_ax_t ar,
   input  logic             arvalid,
   output logic             arready,
   output axi_pkg::axi_r_t  r,
   output logic             rvalid,
   input  logic             rready
);
   import axi_pkg::*;
   import sys_bus_pkg::*;

   // captured request
   axi_id_t   wr_id;
   axi_addr_t wr_addr;
   axi_data_t wr_data;
   axi_strb_t wr_strb;
   logic      wr_unsup;
   axi_id_t   rd_id;
   axi_addr_t rd_addr;
   logic      rd_unsup;
   logic      aw_load;
   logic      w_load;
   logic      ar_load;
   // system bus
   sys_req_t  sys_req;
   sys_rsp_t  sys_rsp;
   logic      wen;
   logic      ren;
   // response path
   logic      b_set;
   logic      r_set;
   logic      resp_err;
   axi_data_t rd_data;
   logic      resp_done;

   axi_wr_capture i_wr_capture (
      .axi      (axi),
      .rst      (rst),
      .aw       (aw),
      .w        (w),
      .aw_load  (aw_load),
      .w_load   (w_load),
      .wr_id    (wr_id),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_strb  (wr_strb),
      .wr_unsup (wr_unsup)
   );

   axi_rd_capture i_rd_capture (
      .axi      (axi),
      .rst      (rst),
      .ar       (ar),
      .ar_load  (ar_load),
      .rd_id    (rd_id),
      .rd_addr  (rd_addr),
      .rd_unsup (rd_unsup)
   );

   bridge_ctrl i_ctrl (
      .axi       (axi),
      .rst       (rst),
      .awvalid   (awvalid),
      .awready   (awready),
      .wvalid    (wvalid),
      .wready    (wready),
      .arvalid   (arvalid),
      .arready   (arready),
      .aw_load   (aw_load),
      .w_load    (w_load),
      .ar_load   (ar_load),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .wr_strb   (wr_strb),
      .wr_unsup  (wr_unsup),
      .rd_addr   (rd_addr),
      .rd_unsup  (rd_unsup),
      .sys_req   (sys_req),
      .wen       (wen),
      .ren       (ren),
      .sys_rsp   (sys_rsp),
      .b_set     (b_set),
      .r_set     (r_set),
      .resp_err  (resp_err),
      .rd_data   (rd_data),
      .resp_done (resp_done)
   );

   axi_resp_gen i_resp_gen (
      .axi       (axi),
      .rst       (rst),
      .b_set     (b_set),
      .r_set     (r_set),
      .resp_err  (resp_err),
      .wr_id     (wr_id),
      .rd_id     (rd_id),
      .rd_data   (rd_data),
      .bvalid    (bvalid),
      .b         (b),
      .bready    (bready),
      .rvalid    (rvalid),
      .r         (r),
      .rready    (rready),
      .resp_done (resp_done)
   );

   // the only peripheral behind the bridge
   sys_reg_bank i_reg_bank (
      .axi     (axi),
      .rst     (rst),
      .sys_req (sys_req),
      .wen     (wen),
      .ren     (ren),
      .sys_rsp (sys_rsp)
   );

endmodule

// ==== tb/tb_axi_sys_bridge.sv ====
// bridge testbench with clock, reset, watchdog, check task, axi driver tasks and directed tests
`include "axi_bridge_defines.svh"

module tb_axi_sys_bridge;
   import axi_pkg::*;

   localparam int CYC_LIMIT = 4000;   // far above the few hundred cycles the six tests take
   localparam int REG_BYTES = `REG_COUNT * 4;

   logic      axi = 1'b0;
   logic      rst;
   axi_ax_t   aw;
   logic      awvalid;
   logic      awready;
   axi_w_t    w;
   logic      wvalid;
   logic      wready;
   axi_b_t    b;
   logic      bvalid;
   logic      bready;
   axi_ax_t   ar;
   logic      arvalid;
   logic      arready;
   axi_r_t    r;
   logic      rvalid;
   logic      rready;

   axi_data_t ref_regs [`REG_COUNT];   // expected register contents
   int        errors = 0;
   int        checks = 0;
   int        cyc = 0;                 // posedge count read at negedge

   axi_sys_bridge_top i_dut (
      .axi     (axi),
      .rst     (rst),
      .aw      (aw),
      .awvalid (awvalid),
      .awready (awready),
      .w       (w),
      .wvalid  (wvalid),
      .wready  (wready),
      .b       (b),
      .bvalid  (bvalid),
      .bready  (bready),
      .ar      (ar),
      .arvalid (arvalid),
      .arready (arready),
      .r       (r),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   always #50 axi = ~axi;   // period 100

   // watchdog
   always @(posedge axi) begin
      cyc <= cyc + 1;
      if (cyc >= CYC_LIMIT) begin
         $display("run stopped after %0d cycles without finishing the tests", CYC_LIMIT);
         $display("Test failures found");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // checking and reference model
   //////////////////////////////////////////////////

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   // byte-select update that skips unmapped words
   function automatic void model_write(input axi_addr_t addr, input axi_data_t data,
                                       input axi_strb_t strb);
      if (addr < REG_BYTES) begin
         for (int k = 0; k < $bits(axi_strb_t); k++) begin
            if (strb[k])
               ref_regs[addr >> 2][8*k +: 8] = data[8*k +: 8];
         end
      end
   endfunction

   //////////////////////////////////////////////////
   // axi driver tasks sampling at negedge
   //////////////////////////////////////////////////

   task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                            input axi_id_t tid, input axi_len_t len, input axi_size_t size,
                            input int hold, output axi_b_t b_got, output int lat,
                            output int done_cyc);
      int     t_addr;
      axi_b_t b_first;
      aw      = '{id: tid, addr: addr, len: len, size: size};
      w       = '{id: tid, data: data, strb: strb};
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge axi);
      while (!awready) @(negedge axi);   // aw goes at the next edge
      t_addr = cyc;
      @(posedge axi);
      #10 awvalid = 1'b0;
      @(negedge axi);
      while (!wready) @(negedge axi);
      @(posedge axi);
      #10 wvalid = 1'b0;
      @(negedge axi);
      while (!bvalid) @(negedge axi);
      done_cyc = cyc;
      lat      = done_cyc - t_addr;
      b_first  = b;
      repeat (hold) begin   // master stalls while the beat holds
         @(negedge axi);
         check("bvalid", bvalid, 1'b1);
         check("b", b, b_first);
      end
      @(posedge axi);
      #10 bready = 1'b1;
      @(negedge axi);
      check("bvalid", bvalid, 1'b1);
      @(posedge axi);
      #10 bready = 1'b0;
      b_got = b_first;
   endtask

   task automatic axi_read(input axi_addr_t addr, input axi_id_t tid, input axi_len_t len,
                           input axi_size_t size, input int hold, output axi_r_t r_got,
                           output int lat, output int done_cyc);
      int     t_addr;
      axi_r_t r_first;
      ar      = '{id: tid, addr: addr, len: len, size: size};
      arvalid = 1'b1;
      @(negedge axi);
      while (!arready) @(negedge axi);   // low while a write is pending
      t_addr = cyc;
      @(posedge axi);
      #10 arvalid = 1'b0;
      @(negedge axi);
      while (!rvalid) @(negedge axi);
      done_cyc = cyc;
      lat      = done_cyc - t_addr;
      r_first  = r;
      repeat (hold) begin
         @(negedge axi);
         check("rvalid", rvalid, 1'b1);
         check("r", r, r_first);
      end
      @(posedge axi);
      #10 rready = 1'b1;
      @(negedge axi);
      check("rvalid", rvalid, 1'b1);
      @(posedge axi);
      #10 rready = 1'b0;
      r_got = r_first;
   endtask

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic reset_state;
      @(negedge axi);
      check("awready", awready, 1'b1);
      check("arready", arready, 1'b1);
      check("wready", wready, 1'b0);
      check("bvalid", bvalid, 1'b0);
      check("rvalid", rvalid, 1'b0);
      @(posedge axi);
      #10;
   endtask

   task automatic reg_access;
      axi_b_t    bg;
      axi_r_t    rg;
      int        lat;
      int        dc;
      axi_data_t data;
      for (int i = 0; i < `REG_COUNT; i++) begin
         data = $urandom;
         axi_write(axi_addr_t'(i * 4), data, 4'hf, axi_id_t'(i), 4'd0, SIZE_4B, 0, bg, lat, dc);
         model_write(axi_addr_t'(i * 4), data, 4'hf);
         check("b.resp", bg.resp, RESP_OKAY);
         check("b.id", bg.id, axi_id_t'(i));
      end
      // two byte lanes only
      axi_write(32'h8, 32'ha5a5_5a5a, 4'b0101, 4'hc, 4'd0, SIZE_4B, 0, bg, lat, dc);
      model_write(32'h8, 32'ha5a5_5a5a, 4'b0101);
      check("b.resp", bg.resp, RESP_OKAY);
      check("b.id", bg.id, 4'hc);
      for (int i = 0; i < `REG_COUNT; i++) begin
         axi_read(axi_addr_t'(i * 4), axi_id_t'(i + 3), 4'd0, SIZE_4B, 0, rg, lat, dc);
         check("r.resp", rg.resp, RESP_OKAY);
         check("r.id", rg.id, axi_id_t'(i + 3));
         check("r.last", rg.last, 1'b1);
         check($sformatf("r.data reg %0d", i), rg.data, ref_regs[i]);
      end
   endtask

   task automatic unsupported_xfers;
      axi_b_t bg;
      axi_r_t rg;
      int     lat;
      int     dc;
      axi_write(32'hc, 32'hdead_beef, 4'hf, 4'h5, 4'd1, SIZE_4B, 0, bg, lat, dc);   // burst
      check("b.resp", bg.resp, RESP_SLVERR);
      axi_write(32'hc, 32'hdead_beef, 4'hf, 4'h6, 4'd0, 3'd1, 0, bg, lat, dc);      // halfword
      check("b.resp", bg.resp, RESP_SLVERR);
      axi_read(32'hc, 4'h7, 4'd3, SIZE_4B, 0, rg, lat, dc);
      check("r.resp", rg.resp, RESP_SLVERR);
      axi_read(32'hc, 4'h8, 4'd0, SIZE_4B, 0, rg, lat, dc);
      check("r.resp", rg.resp, RESP_OKAY);
      check("r.data reg 3", rg.data, ref_regs[3]);   // untouched
   endtask

   task automatic unmapped_timeout;
      axi_b_t bg;
      axi_r_t rg;
      int     lat;
      int     dc;
      axi_write(REG_BYTES + 32'h40, 32'h1234_5678, 4'hf, 4'h9, 4'd0, SIZE_4B, 0, bg, lat, dc);
      check("b.resp", bg.resp, RESP_SLVERR);
      if (lat < `ACK_TIMEOUT) begin
         errors++;
         $display("write to an unmapped address answered after %0d cycles, before the timeout",
                  lat);
      end
      axi_read(32'h0000_1000, 4'ha, 4'd0, SIZE_4B, 0, rg, lat, dc);
      check("r.resp", rg.resp, RESP_SLVERR);
      check("r.data", rg.data, 32'h0);
      if (lat < `ACK_TIMEOUT) begin
         errors++;
         $display("read from an unmapped address answered after %0d cycles, before the timeout",
                  lat);
      end
   endtask

   task automatic write_priority;
      axi_b_t bg;
      axi_r_t rg;
      int     wlat;
      int     rlat;
      int     b_cyc;
      int     r_cyc;
      fork   // aw and ar raised in the same cycle
         axi_write(32'h14, 32'h0bad_f00d, 4'hf, 4'h1, 4'd0, SIZE_4B, 0, bg, wlat, b_cyc);
         axi_read(32'h14, 4'h2, 4'd0, SIZE_4B, 0, rg, rlat, r_cyc);
      join
      model_write(32'h14, 32'h0bad_f00d, 4'hf);
      check("b.resp", bg.resp, RESP_OKAY);
      check("r.resp", rg.resp, RESP_OKAY);
      check("r.data reg 5", rg.data, ref_regs[5]);
      if (b_cyc >= r_cyc) begin
         errors++;
         $display("read response came before the write response of the same cycle");
      end
   endtask

   task automatic backpressure;
      axi_b_t    bg;
      axi_r_t    rg;
      int        lat;
      int        dc;
      int        idx;
      axi_data_t data;
      for (int n = 0; n < 5; n++) begin
         idx  = $urandom_range(`REG_COUNT - 1, 0);
         data = $urandom;
         // last round without stalls
         axi_write(axi_addr_t'(idx * 4), data, 4'hf, axi_id_t'(n), 4'd0, SIZE_4B,
                   (n < 4) ? $urandom_range(10, 0) : 0, bg, lat, dc);
         model_write(axi_addr_t'(idx * 4), data, 4'hf);
         check("b.resp", bg.resp, RESP_OKAY);
         check("b.id", bg.id, axi_id_t'(n));
         axi_read(axi_addr_t'(idx * 4), axi_id_t'(n + 8), 4'd0, SIZE_4B,
                  (n < 4) ? $urandom_range(10, 0) : 0, rg, lat, dc);
         check("r.resp", rg.resp, RESP_OKAY);
         check("r.id", rg.id, axi_id_t'(n + 8));
         check($sformatf("r.data reg %0d", idx), rg.data, ref_regs[idx]);
      end
   endtask

   //////////////////////////////////////////////////
   // run
   //////////////////////////////////////////////////

   initial begin
      rst     = 1'b1;
      aw      = '0;
      awvalid = 1'b0;
      w       = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      ar      = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      void'($urandom(32'h3580));
      for (int i = 0; i < `REG_COUNT; i++)
         ref_regs[i] = '0;
      repeat (16) @(posedge axi);
      #10 rst = 1'b0;

      reset_state();
      reg_access();
      unsupported_xfers();
      unmapped_timeout();
      write_priority();
      backpressure();

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+src
src/axi_pkg.sv
src/sys_bus_pkg.sv
src/axi_wr_capture.sv
src/axi_rd_capture.sv
src/bridge_ctrl.sv
src/axi_resp_gen.sv
src/sys_reg_bank.sv
src/axi_sys_bridge_top.sv
tb/tb_axi_sys_bridge.sv
